/* source/id_params.svh */
// Decode stage parameters
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

// Datapath width
`define ID_DATA_W 16

// Register number width and register count
`define ID_REG_ADDR_W 4
`define ID_NUM_REGS (1 << `ID_REG_ADDR_W)

// Special registers
`define ID_DATA_REG 4'd14 // Data segment register
`define ID_STACK_REG 4'd15 // Stack pointer

// Stack pointer value loaded while rst is high
// Top of the data memory
`define ID_SP_RESET {`ID_DATA_W{1'b1}}

`endif

/* source/id_pkg.sv */
// Decode stage types
package id_pkg;

    // Instruction opcode, Inst[15:12]
    typedef enum logic [3:0] {
        op_add  = 4'h0, // Two-register arithmetic
        op_sub  = 4'h1,
        op_and  = 4'h2, // Two-register logic
        op_nor  = 4'h3,
        op_sll  = 4'h4, // Shifts by 4-bit imm
        op_srl  = 4'h5,
        op_sra  = 4'h6,
        op_lw   = 4'h7, // Load word, data segment relative
        op_sw   = 4'h8, // Save word
        op_lhb  = 4'h9, // Load high byte
        op_llb  = 4'ha, // Load low byte
        op_b    = 4'hb, // Conditional branch
        op_call = 4'hc,
        op_ret  = 4'hd,
        op_nop  = 4'he,
        op_hlt  = 4'hf
    } opcode_e;

    // ALU operation, alu_pass when idle or bubbled
    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_sub  = 3'd1,
        alu_and  = 3'd2,
        alu_nor  = 3'd3,
        alu_sll  = 3'd4,
        alu_srl  = 3'd5,
        alu_sra  = 3'd6,
        alu_pass = 3'd7
    } alu_op_e;

    // PC hazard hold state
    typedef enum logic {
        pc_idle = 1'b0, // No call or ret outstanding
        pc_wait = 1'b1  // Waiting on fetch side PC update
    } pc_state_e;

endpackage

/* source/reg_file_16.sv */
// Sixteen-entry register file
`timescale 1ns/1ns
`include "id_params.svh"

module reg_file_16 (
    input  logic                      clk,
    input  logic                      reg_write,   // Write enable
    input  logic                      data_reg,    // Port 1 reads R14
    input  logic                      stack_reg,   // Port 1 reads R15
    input  logic [`ID_REG_ADDR_W-1:0] read_reg_1,  // rs
    input  logic [`ID_REG_ADDR_W-1:0] read_reg_2,  // rt or load/save reg
    input  logic [`ID_REG_ADDR_W-1:0] write_reg,
    input  logic [`ID_DATA_W-1:0]     write_data,
    output logic [`ID_DATA_W-1:0]     read_data_1,
    output logic [`ID_DATA_W-1:0]     read_data_2
);

    logic [`ID_DATA_W-1:0]     regs [0:`ID_NUM_REGS-1]; // Register array
    logic [`ID_REG_ADDR_W-1:0] addr_1;                  // Port 1 after special select

    // Write on rising edge, R0 stays zero
    always_ff @(posedge clk) begin
        if (reg_write && (write_reg != '0)) begin
            regs[write_reg] <= write_data;
        end
    end

    // Special register override on port 1
    always_comb begin
        if (stack_reg) begin
            addr_1 = `ID_STACK_REG;
        end else if (data_reg) begin
            addr_1 = `ID_DATA_REG;
        end else begin
            addr_1 = read_reg_1;
        end
    end

    // Asynchronous reads
    always_comb begin
        if (addr_1 == '0) begin
            read_data_1 = '0; // R0 hardwired
        end else begin
            read_data_1 = regs[addr_1];
        end

        if (read_reg_2 == '0) begin
            read_data_2 = '0;
        end else begin
            read_data_2 = regs[read_reg_2];
        end
    end

endmodule

/* source/control_logic.sv */
// Opcode control decoder
`timescale 1ns/1ns

module control_logic (
    input  id_pkg::opcode_e opcode,
    output logic            reg_write,    // Writes a register
    output logic            mem_write,    // Save word
    output logic            mem_read,     // Load word
    output logic            mem_to_reg,   // Write-back from memory
    output logic            alu_src,      // ALU operand B is the immediate
    output id_pkg::alu_op_e alu_op,
    output logic            branch,
    output logic            call,
    output logic            ret,
    output logic            load_half,    // LHB or LLB
    output logic            half_spec,    // 0 -> LHB, 1 -> LLB
    output logic            data_reg,     // Read port 1 gives R14
    output logic            stack_reg,    // Read port 1 gives R15
    output logic            reg_rt_src,   // rt from load/save reg field
    output logic            sign_ext_sel, // 1 -> load/save imm
    output logic            uses_rs,      // rs read, for hazard check
    output logic            uses_rt,      // rt read, for hazard check
    output logic            halt
);

    always_comb begin
        // Idle defaults, same as nop
        reg_write    = 1'b0;
        mem_write    = 1'b0;
        mem_read     = 1'b0;
        mem_to_reg   = 1'b0;
        alu_src      = 1'b0;
        alu_op       = id_pkg::alu_pass;
        branch       = 1'b0;
        call         = 1'b0;
        ret          = 1'b0;
        load_half    = 1'b0;
        half_spec    = 1'b0;
        data_reg     = 1'b0;
        stack_reg    = 1'b0;
        reg_rt_src   = 1'b0;
        sign_ext_sel = 1'b0;
        uses_rs      = 1'b0;
        uses_rt      = 1'b0;
        halt         = 1'b0;

        case (opcode)
            id_pkg::op_add, id_pkg::op_sub, id_pkg::op_and, id_pkg::op_nor: begin
                reg_write = 1'b1;
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
                // Low two opcode bits map straight onto the ALU code
                alu_op    = id_pkg::alu_op_e'({1'b0, opcode[1:0]});
            end
            id_pkg::op_sll, id_pkg::op_srl, id_pkg::op_sra: begin
                reg_write = 1'b1;
                uses_rs   = 1'b1;
                alu_src   = 1'b1; // Shift amount from imm
                alu_op    = id_pkg::alu_op_e'(opcode[2:0]);
            end
            id_pkg::op_lw: begin
                reg_write    = 1'b1;
                mem_read     = 1'b1;
                mem_to_reg   = 1'b1;
                alu_src      = 1'b1;
                alu_op       = id_pkg::alu_add; // R14 + offset
                data_reg     = 1'b1;
                sign_ext_sel = 1'b1;
                uses_rs      = 1'b1;
            end
            id_pkg::op_sw: begin
                mem_write    = 1'b1;
                alu_src      = 1'b1;
                alu_op       = id_pkg::alu_add;
                data_reg     = 1'b1;
                sign_ext_sel = 1'b1;
                reg_rt_src   = 1'b1; // Store data from load/save reg
                uses_rs      = 1'b1;
                uses_rt      = 1'b1;
            end
            id_pkg::op_lhb: begin
                reg_write = 1'b1;
                load_half = 1'b1;
            end
            id_pkg::op_llb: begin
                reg_write = 1'b1;
                load_half = 1'b1;
                half_spec = 1'b1;
            end
            id_pkg::op_b:    branch = 1'b1;
            id_pkg::op_call: begin
                call      = 1'b1;
                stack_reg = 1'b1; // Push through SP
                uses_rs   = 1'b1;
            end
            id_pkg::op_ret: begin
                ret       = 1'b1;
                stack_reg = 1'b1; // Pop through SP
                uses_rs   = 1'b1;
            end
            id_pkg::op_hlt:  halt = 1'b1;
            default: ; // nop keeps the defaults
        endcase
    end

endmodule

/* source/hazard_unit.sv */
// Data and PC hazard detection
`timescale 1ns/1ns
`include "id_params.svh"

module hazard_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`ID_REG_ADDR_W-1:0] src_rs,        // Effective rs with R14/R15 substituted
    input  logic [`ID_REG_ADDR_W-1:0] src_rt,        // Effective rt after mux
    input  logic                      uses_rs,
    input  logic                      uses_rt,
    input  logic [`ID_REG_ADDR_W-1:0] id_ex_reg_rd,
    input  logic [`ID_REG_ADDR_W-1:0] ex_mem_reg_rd,
    input  logic [`ID_REG_ADDR_W-1:0] mem_wb_reg_rd,
    input  logic                      call,          // Raw decode before the bubble
    input  logic                      ret,
    input  logic                      pc_update,     // One-cycle strobe from fetch
    output logic                      data_hazard,
    output logic                      pc_hazard
);

    id_pkg::pc_state_e pc_state;

    // Source matches a pending destination and is not R0
    function automatic logic pending(input logic [`ID_REG_ADDR_W-1:0] src,
                                     input logic [`ID_REG_ADDR_W-1:0] rd_ex,
                                     input logic [`ID_REG_ADDR_W-1:0] rd_mem,
                                     input logic [`ID_REG_ADDR_W-1:0] rd_wb);
        logic hit;
        hit = (src == rd_ex) || (src == rd_mem) || (src == rd_wb);
        return (src != '0) && hit;
    endfunction

    // RAW check against the three later stages
    assign data_hazard =
        (uses_rs && pending(src_rs, id_ex_reg_rd, ex_mem_reg_rd, mem_wb_reg_rd)) ||
        (uses_rt && pending(src_rt, id_ex_reg_rd, ex_mem_reg_rd, mem_wb_reg_rd));

    // Hold the PC hazard until fetch reports the new PC
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_state <= id_pkg::pc_idle;
        end else begin
            case (pc_state)
                id_pkg::pc_idle: begin
                    if ((call || ret) && !data_hazard) begin
                        pc_state <= id_pkg::pc_wait; // Call/ret leaves decode
                    end
                end
                id_pkg::pc_wait: begin
                    if (pc_update) begin
                        pc_state <= id_pkg::pc_idle;
                    end
                end
                default: pc_state <= id_pkg::pc_idle;
            endcase
        end
    end

    assign pc_hazard = (pc_state == id_pkg::pc_wait); // Registered

endmodule

/* source/id_unit.sv */
// Instruction decode stage
`timescale 1ns/1ns
`include "id_params.svh"

module id_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pc_update,        // PC written by fetch side
    input  logic                      pc_hazard_in,     // Bubble request from PC logic
    input  logic                      reg_write_in,     // Write-back enable
    input  logic [`ID_REG_ADDR_W-1:0] reg_rs,           // Inst[7:4]
    input  logic [`ID_REG_ADDR_W-1:0] reg_rt_arith,     // Inst[3:0]
    input  logic [`ID_REG_ADDR_W-1:0] reg_rd_wb,        // Write-back register
    input  logic [`ID_DATA_W-1:0]     reg_rd_data,      // Write-back data
    input  id_pkg::opcode_e           opcode,           // Inst[15:12]
    input  logic [2:0]                branch_cond_in,   // Inst[10:8]
    input  logic [3:0]                arith_imm_in,     // Inst[3:0]
    input  logic [`ID_REG_ADDR_W-1:0] load_save_reg_in, // Inst[11:8]
    input  logic [7:0]                load_save_imm_in, // Inst[7:0]
    input  logic [11:0]               call_target_in,   // Inst[11:0]
    input  logic [`ID_DATA_W-1:0]     pc_in,
    input  logic [`ID_REG_ADDR_W-1:0] id_ex_reg_rd,
    input  logic [`ID_REG_ADDR_W-1:0] ex_mem_reg_rd,
    input  logic [`ID_REG_ADDR_W-1:0] mem_wb_reg_rd,
    output logic                      reg_write_out,
    output logic                      mem_write_out,
    output logic                      mem_read_out,
    output logic                      mem_to_reg,
    output logic                      alu_src,
    output id_pkg::alu_op_e           alu_op,
    output logic                      branch,
    output logic                      call,
    output logic                      ret,
    output logic                      load_half,
    output logic                      half_spec,
    output logic [`ID_DATA_W-1:0]     read_data_1,
    output logic [`ID_DATA_W-1:0]     read_data_2,
    output logic [2:0]                branch_cond_out,
    output logic [`ID_REG_ADDR_W-1:0] load_save_reg_out,
    output logic [3:0]                arith_imm_out,
    output logic [7:0]                load_save_imm_out,
    output logic [11:0]               call_target_out,
    output logic [`ID_DATA_W-1:0]     pc_out,
    output logic [`ID_DATA_W-1:0]     sign_ext_out,
    output logic                      data_hazard,
    output logic                      pc_hazard_out,
    output logic                      halt              // Never bubbled
);

    // Raw decoder outputs
    logic            c_reg_write, c_mem_write, c_mem_read, c_mem_to_reg, c_alu_src;
    logic            c_branch, c_call, c_ret, c_load_half, c_half_spec;
    id_pkg::alu_op_e c_alu_op;
    logic            data_reg, stack_reg, reg_rt_src, sign_ext_sel, uses_rs, uses_rt;

    logic [`ID_REG_ADDR_W-1:0] reg_rt;     // rt after source mux
    logic [`ID_REG_ADDR_W-1:0] src_rs;     // rs as the regfile really reads it
    logic [`ID_DATA_W-1:0]     rf_data_1, rf_data_2;
    logic [`ID_DATA_W-1:0]     sign_ext;
    logic                      wr_en;      // Regfile write port after reset mux
    logic [`ID_REG_ADDR_W-1:0] wr_reg;
    logic [`ID_DATA_W-1:0]     wr_data;
    logic                      bubble;

    reg_file_16 reg_mem (
        .clk(clk), .reg_write(wr_en), .data_reg(data_reg), .stack_reg(stack_reg),
        .read_reg_1(reg_rs), .read_reg_2(reg_rt), .write_reg(wr_reg),
        .write_data(wr_data), .read_data_1(rf_data_1), .read_data_2(rf_data_2)
    );

    control_logic control (
        .opcode(opcode), .reg_write(c_reg_write), .mem_write(c_mem_write),
        .mem_read(c_mem_read), .mem_to_reg(c_mem_to_reg), .alu_src(c_alu_src),
        .alu_op(c_alu_op), .branch(c_branch), .call(c_call), .ret(c_ret),
        .load_half(c_load_half), .half_spec(c_half_spec), .data_reg(data_reg),
        .stack_reg(stack_reg), .reg_rt_src(reg_rt_src), .sign_ext_sel(sign_ext_sel),
        .uses_rs(uses_rs), .uses_rt(uses_rt), .halt(halt)
    );

    hazard_unit hazards (
        .clk(clk), .rst(rst), .src_rs(src_rs), .src_rt(reg_rt),
        .uses_rs(uses_rs), .uses_rt(uses_rt), .id_ex_reg_rd(id_ex_reg_rd),
        .ex_mem_reg_rd(ex_mem_reg_rd), .mem_wb_reg_rd(mem_wb_reg_rd),
        .call(c_call), .ret(c_ret), .pc_update(pc_update),
        .data_hazard(data_hazard), .pc_hazard(pc_hazard_out)
    );

    // sw stores from the load/save register
    assign reg_rt = reg_rt_src ? load_save_reg_in : reg_rt_arith;

    // Mirror the regfile port 1 override for hazard compare
    assign src_rs = stack_reg ? `ID_STACK_REG : (data_reg ? `ID_DATA_REG : reg_rs);

    // Sign extension, load/save imm for lw/sw
    assign sign_ext = sign_ext_sel ? {{8{load_save_imm_in[7]}}, load_save_imm_in}
                                   : {{12{arith_imm_in[3]}}, arith_imm_in};

    assign bubble = data_hazard || pc_hazard_in;

    // Bubble mux, zeros keep downstream stages idle
    always_comb begin
        reg_write_out     = bubble ? 1'b0 : c_reg_write;
        mem_write_out     = bubble ? 1'b0 : c_mem_write;
        mem_read_out      = bubble ? 1'b0 : c_mem_read;
        mem_to_reg        = bubble ? 1'b0 : c_mem_to_reg;
        alu_src           = bubble ? 1'b0 : c_alu_src;
        alu_op            = bubble ? id_pkg::alu_pass : c_alu_op;
        branch            = bubble ? 1'b0 : c_branch;
        call              = bubble ? 1'b0 : c_call;
        ret               = bubble ? 1'b0 : c_ret;
        load_half         = bubble ? 1'b0 : c_load_half;
        half_spec         = bubble ? 1'b0 : c_half_spec;
        read_data_1       = bubble ? '0 : rf_data_1;
        read_data_2       = bubble ? '0 : rf_data_2;
        load_save_reg_out = bubble ? '0 : load_save_reg_in;
        arith_imm_out     = bubble ? '0 : arith_imm_in;
        load_save_imm_out = bubble ? '0 : load_save_imm_in;
        sign_ext_out      = bubble ? '0 : sign_ext;
        branch_cond_out   = branch_cond_in; // PC side always sees these
        call_target_out   = call_target_in;
        pc_out            = pc_in;
    end

    // Reset loads the stack pointer
    always_comb begin
        if (rst) begin
            wr_en   = 1'b1;
            wr_reg  = `ID_STACK_REG;
            wr_data = `ID_SP_RESET;
        end else begin
            wr_en   = reg_write_in;
            wr_reg  = reg_rd_wb;
            wr_data = reg_rd_data;
        end
    end

endmodule

/* tests/id_unit_tb.sv */
// Decode stage testbench
`timescale 1ns/1ns
`include "id_params.svh"

module id_unit_tb;

    localparam int RESET_CYCLES = 5;

    // One table row, all fields as int for easy writing
    typedef struct packed {
        id_pkg::opcode_e op;
        int rs, rt, ls_reg, a_imm, ls_imm; // Instruction fields
        int d_ex, d_mem, d_wb;             // Downstream destinations
        int phz_in, pc_upd, wb_en, wb_reg;
        int exp_dh, exp_phz;               // Expected hazards
    } row_t;

    logic                      clk, rst, pc_update, pc_hazard_in, reg_write_in;
    logic [`ID_REG_ADDR_W-1:0] reg_rs, reg_rt_arith, reg_rd_wb, load_save_reg_in;
    logic [`ID_REG_ADDR_W-1:0] id_ex_reg_rd, ex_mem_reg_rd, mem_wb_reg_rd, load_save_reg_out;
    logic [`ID_DATA_W-1:0]     reg_rd_data, pc_in, pc_out, sign_ext_out;
    logic [`ID_DATA_W-1:0]     read_data_1, read_data_2;
    logic [3:0]                arith_imm_in, arith_imm_out;
    logic [2:0]                branch_cond_in, branch_cond_out;
    logic [7:0]                load_save_imm_in, load_save_imm_out;
    logic [11:0]               call_target_in, call_target_out;
    id_pkg::opcode_e           opcode;
    id_pkg::alu_op_e           alu_op;
    logic                      reg_write_out, mem_write_out, mem_read_out, mem_to_reg, alu_src;
    logic                      branch, call, ret, load_half, half_spec, halt;
    logic                      data_hazard, pc_hazard_out;

    row_t                  rows[$];
    logic [`ID_DATA_W-1:0] shadow [0:15];  // Register contents as the TB expects them
    logic [31:0]           lfsr = 32'hcbb3;
    int                    cycles = 0;

    id_unit UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run limit from table length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > rows.size() * 4 + RESET_CYCLES) begin
            $display("tests failed");
            $fatal(1, "timeout after %0d cycles, the table never finished", cycles);
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [15:0] random_word();
        logic [15:0] word;
        logic        fb;
        int          b;
        word = '0;
        for (b = 0; b < 16; b++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb}; // One step per bit
            word = {word[14:0], fb};
        end
        return word;
    endfunction

    // Expected {rw, mw, mr, m2r, src, alu_op, br, call, ret, lh, hs, halt}
    function automatic logic [13:0] ref_decode(input id_pkg::opcode_e op);
        case (op)
            id_pkg::op_add:  return {5'b10000, id_pkg::alu_add, 6'b000000};
            id_pkg::op_sub:  return {5'b10000, id_pkg::alu_sub, 6'b000000};
            id_pkg::op_and:  return {5'b10000, id_pkg::alu_and, 6'b000000};
            id_pkg::op_nor:  return {5'b10000, id_pkg::alu_nor, 6'b000000};
            id_pkg::op_sll:  return {5'b10001, id_pkg::alu_sll, 6'b000000}; // Imm operand
            id_pkg::op_srl:  return {5'b10001, id_pkg::alu_srl, 6'b000000};
            id_pkg::op_sra:  return {5'b10001, id_pkg::alu_sra, 6'b000000};
            id_pkg::op_lw:   return {5'b10111, id_pkg::alu_add, 6'b000000}; // R14 + offset
            id_pkg::op_sw:   return {5'b01001, id_pkg::alu_add, 6'b000000};
            id_pkg::op_lhb:  return {5'b10000, id_pkg::alu_pass, 6'b000100};
            id_pkg::op_llb:  return {5'b10000, id_pkg::alu_pass, 6'b000110};
            id_pkg::op_b:    return {5'b00000, id_pkg::alu_pass, 6'b100000};
            id_pkg::op_call: return {5'b00000, id_pkg::alu_pass, 6'b010000};
            id_pkg::op_ret:  return {5'b00000, id_pkg::alu_pass, 6'b001000};
            id_pkg::op_hlt:  return {5'b00000, id_pkg::alu_pass, 6'b000001};
            default:         return {5'b00000, id_pkg::alu_pass, 6'b000000}; // nop
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic drive_row(input row_t r, input int idx);
        opcode           = r.op;
        reg_rs           = r.rs[3:0];
        reg_rt_arith     = r.rt[3:0];
        load_save_reg_in = r.ls_reg[3:0];
        arith_imm_in     = r.a_imm[3:0];
        load_save_imm_in = r.ls_imm[7:0];
        id_ex_reg_rd     = r.d_ex[3:0];
        ex_mem_reg_rd    = r.d_mem[3:0];
        mem_wb_reg_rd    = r.d_wb[3:0];
        pc_hazard_in     = r.phz_in[0];
        pc_update        = r.pc_upd[0];  // Strobe lasts one row
        reg_write_in     = r.wb_en[0];
        reg_rd_wb        = r.wb_reg[3:0];
        reg_rd_data      = random_word();
        branch_cond_in   = idx[2:0];     // Pass-through fields vary per row
        call_target_in   = 12'hf00 | idx[11:0];
        pc_in            = 16'h0100 + idx[15:0];
    endtask

    task automatic check_row(input row_t r);
        logic [3:0]            eff_rs, eff_rt;
        logic [`ID_DATA_W-1:0] exp_rd1, exp_rd2, exp_ext;
        logic [13:0]           raw, exp_ctrl;
        logic                  bubble;
        bubble = (r.exp_dh != 0) || (r.phz_in != 0);
        raw    = ref_decode(r.op);
        if (r.op == id_pkg::op_call || r.op == id_pkg::op_ret) begin
            eff_rs = `ID_STACK_REG;
        end else if (r.op == id_pkg::op_lw || r.op == id_pkg::op_sw) begin
            eff_rs = `ID_DATA_REG;
        end else begin
            eff_rs = r.rs[3:0];
        end
        eff_rt  = (r.op == id_pkg::op_sw) ? r.ls_reg[3:0] : r.rt[3:0]; // Store data reg
        exp_rd1 = (bubble || eff_rs == 4'd0) ? '0 : shadow[eff_rs];
        exp_rd2 = (bubble || eff_rt == 4'd0) ? '0 : shadow[eff_rt];
        if (r.op == id_pkg::op_lw || r.op == id_pkg::op_sw) begin
            exp_ext = {{8{r.ls_imm[7]}}, r.ls_imm[7:0]};
        end else begin
            exp_ext = {{12{r.a_imm[3]}}, r.a_imm[3:0]};
        end
        exp_ctrl = bubble ? {5'b00000, id_pkg::alu_pass, 5'b00000, raw[0]} : raw; // Halt kept
        check("controls", 32'({reg_write_out, mem_write_out, mem_read_out, mem_to_reg, alu_src,
              alu_op, branch, call, ret, load_half, half_spec, halt}), 32'(exp_ctrl));
        check("read_data_1", 32'(read_data_1), 32'(exp_rd1));
        check("read_data_2", 32'(read_data_2), 32'(exp_rd2));
        check("sign_ext_out", 32'(sign_ext_out), bubble ? 32'd0 : 32'(exp_ext));
        check("data_hazard", 32'(data_hazard), r.exp_dh);
        check("pc_hazard_out", 32'(pc_hazard_out), r.exp_phz);
        check("arith_imm_out", 32'(arith_imm_out), bubble ? 32'd0 : 32'(r.a_imm[3:0]));
        check("load_save_imm_out", 32'(load_save_imm_out), bubble ? 32'd0 : 32'(r.ls_imm[7:0]));
        check("load_save_reg_out", 32'(load_save_reg_out), bubble ? 32'd0 : 32'(r.ls_reg[3:0]));
        check("branch_cond_out", 32'(branch_cond_out), 32'(branch_cond_in));
        check("call_target_out", 32'(call_target_out), 32'(call_target_in));
        check("pc_out", 32'(pc_out), 32'(pc_in));
        if (r.wb_en != 0 && r.wb_reg != 0) begin
            shadow[r.wb_reg[3:0]] = reg_rd_data; // Visible from the next row
        end
    endtask

    // op, rs, rt, ls_reg, a_imm, ls_imm, d_ex, d_mem, d_wb, phz_in, pc_upd, wb_en, wb_reg, dh, phz
    task automatic build_table();
        rows.push_back('{id_pkg::op_ret, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0}); // SP read
        rows.push_back('{id_pkg::op_nop, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0, 0, 1}); // R0 write
        for (int i = 1; i < 15; i++) begin
            rows.push_back('{id_pkg::op_nop, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, i, 0, 0});
        end
        rows.push_back('{id_pkg::op_add, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0});
        rows.push_back('{id_pkg::op_nop, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 5, 0, 0});
        rows.push_back('{id_pkg::op_add, 5, 5, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0}); // Readback
        rows.push_back('{id_pkg::op_sub, 1, 2, 0, 7, 'h40, 0, 0, 0, 0, 0, 0, 0, 0, 0});
        rows.push_back('{id_pkg::op_and, 3, 4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0});
        rows.push_back('{id_pkg::op_nor, 6, 7, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0});
        rows.push_back('{id_pkg::op_sll, 2, 8, 0, 9, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0}); // Neg imm
        rows.push_back('{id_pkg::op_srl, 3, 0, 0, 4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0});
        rows.push_back('{id_pkg::op_sra, 4, 1, 0, 'hf, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0});
        rows.push_back('{id_pkg::op_lw, 2, 9, 0, 3, 'h85, 0, 0, 0, 0, 0, 0, 0, 0, 0});
        rows.push_back('{id_pkg::op_sw, 0, 9, 6, 0, 'h12, 0, 0, 0, 0, 0, 0, 0, 0, 0});
        rows.push_back('{id_pkg::op_lhb, 1, 2, 0, 8, 'hab, 0, 0, 0, 0, 0, 0, 0, 0, 0});
        rows.push_back('{id_pkg::op_llb, 0, 0, 0, 2, 'h3c, 0, 0, 0, 0, 0, 0, 0, 0, 0});
        rows.push_back('{id_pkg::op_b, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0});
        rows.push_back('{id_pkg::op_nop, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0});
        rows.push_back('{id_pkg::op_hlt, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0});
        rows.push_back('{id_pkg::op_add, 3, 4, 0, 0, 0, 3, 0, 0, 0, 0, 0, 0, 1, 0}); // rs hit
        rows.push_back('{id_pkg::op_add, 3, 4, 0, 0, 0, 0, 4, 0, 0, 0, 0, 0, 1, 0}); // rt hit
        rows.push_back('{id_pkg::op_add, 0, 7, 0, 0, 0, 0, 2, 9, 0, 0, 0, 0, 0, 0}); // R0 only
        rows.push_back('{id_pkg::op_sll, 2, 8, 0, 0, 0, 0, 0, 8, 0, 0, 0, 0, 0, 0});
        rows.push_back('{id_pkg::op_lw, 1, 0, 0, 0, 0, 14, 0, 0, 0, 0, 0, 0, 1, 0});
        rows.push_back('{id_pkg::op_sw, 0, 9, 6, 0, 0, 0, 6, 0, 0, 0, 0, 0, 1, 0});
        rows.push_back('{id_pkg::op_lhb, 3, 0, 0, 0, 0, 3, 0, 0, 0, 0, 0, 0, 0, 0});
        rows.push_back('{id_pkg::op_add, 3, 4, 0, 5, 'h77, 0, 0, 0, 1, 0, 0, 0, 0, 0});
        rows.push_back('{id_pkg::op_sra, 4, 1, 0, 0, 0, 0, 0, 4, 1, 0, 0, 0, 1, 0});
        rows.push_back('{id_pkg::op_call, 2, 0, 0, 0, 0, 0, 0, 15, 0, 0, 0, 0, 1, 0});
        rows.push_back('{id_pkg::op_call, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0});
        rows.push_back('{id_pkg::op_nop, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1});
        rows.push_back('{id_pkg::op_nop, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1});
        rows.push_back('{id_pkg::op_nop, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 1}); // Strobe
        rows.push_back('{id_pkg::op_nop, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0});
    endtask

    initial begin
        rst    = 1'b1;
        opcode = id_pkg::op_nop;
        {pc_update, pc_hazard_in, reg_write_in, reg_rd_data, pc_in} = '0;
        {reg_rs, reg_rt_arith, reg_rd_wb, load_save_reg_in, arith_imm_in} = '0;
        {id_ex_reg_rd, ex_mem_reg_rd, mem_wb_reg_rd} = '0;
        {branch_cond_in, load_save_imm_in, call_target_in} = '0;
        shadow[`ID_STACK_REG] = `ID_SP_RESET; // Loaded by reset
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (rows[i]) begin
            @(negedge clk);
            drive_row(rows[i], i);
            #5; // Mid low phase
            check_row(rows[i]);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+source
source/id_pkg.sv
source/reg_file_16.sv
source/control_logic.sv
source/hazard_unit.sv
source/id_unit.sv
tests/id_unit_tb.sv

/* Makefile */
# Verilator build and run of the decode stage testbench

TOP = id_unit_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove obj_dir"

test:
	verilator --binary --timescale 1ns/1ns --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "all tests passed"

clean:
	rm -rf obj_dir
